// File: common/cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

// datapath and control widths
`define CU_IR_W       32
`define CU_STATE_W    7
`define CU_OP3_W      6
`define CU_ALUOP_W    6

// instruction field positions
`define CU_OP_HI      31
`define CU_OP_LO      30
`define CU_ANNUL_BIT  29
`define CU_COND_HI    28
`define CU_COND_LO    25
`define CU_OP2_HI     24
`define CU_OP2_LO     22
`define CU_OP3_HI     24
`define CU_OP3_LO     19
`define CU_IMM_BIT    13

`endif

// File: common/isa_pkg.sv
`include "cu_consts.svh"

package isa_pkg;

	// major opcode, ir[31:30]
	typedef enum logic [1:0] {
		op_branch = 2'b00,
		op_call   = 2'b01,
		op_alu    = 2'b10,
		op_mem    = 2'b11
	} op_t;

	// branch group selector
	typedef enum logic [2:0] {
		op2_bicc  = 3'b010,
		op2_sethi = 3'b100
	} op2_t;

	typedef enum logic [3:0] {
		ic_alu,
		ic_alu_cc,
		ic_sethi,
		ic_load,
		ic_store,
		ic_call,
		ic_jmpl,
		ic_br_cond,
		ic_br_always,
		ic_illegal
	} iclass_t;

	localparam logic [`CU_OP3_W-1:0] op3_jmpl = 6'b111000;

	// ba, branch always
	localparam logic [3:0] cond_always = 4'b1000;

endpackage

// File: common/cu_pkg.sv
`include "cu_consts.svh"

package cu_pkg;

	typedef enum logic [`CU_STATE_W-1:0] {
		st_reset        = 7'd0,
		st_fetch_addr   = 7'd1,
		st_fetch_req    = 7'd2,
		st_fetch_wait   = 7'd3,
		st_decode       = 7'd4,
		st_alu_reg      = 7'd10,
		st_alu_imm      = 7'd11,
		st_alu_reg_cc   = 7'd12,
		st_alu_imm_cc   = 7'd13,
		st_sethi        = 7'd14,
		st_ld_addr_reg  = 7'd20,
		st_ld_req       = 7'd21,
		st_ld_wait      = 7'd22,
		st_ld_write     = 7'd23,
		st_st_addr_reg  = 7'd25,
		st_st_data      = 7'd26,
		st_st_wait      = 7'd27,
		st_st_done      = 7'd28,
		st_ld_addr_imm  = 7'd30,
		st_st_addr_imm  = 7'd35,
		st_call_link    = 7'd40,
		st_call_jump    = 7'd41,
		st_jmpl_link    = 7'd42,
		st_jmpl_reg     = 7'd43,
		st_jmpl_imm     = 7'd44,
		st_br_target    = 7'd49,
		st_br_jump      = 7'd50,
		st_br_skip      = 7'd51,
		st_br_annul     = 7'd52,
		st_br_always    = 7'd54
	} cu_state_t;

	// alu function, from_ir lets the alu use op3
	typedef enum logic [`CU_ALUOP_W-1:0] {
		aop_from_ir = 6'b000000,
		aop_pass_b  = 6'b100000,
		aop_add4    = 6'b100001
	} alu_op_t;

	// mux selects and memory access type
	typedef logic [1:0] sel2_t;

endpackage

// File: verilog/instr_decoder.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module instr_decoder (
	input  logic [`CU_IR_W-1:0] ir,
	output isa_pkg::iclass_t    iclass,
	output logic                imm,
	output logic                annul
);
	import isa_pkg::*;

	op_t                  op;
	op2_t                 op2;
	logic [`CU_OP3_W-1:0] op3;
	logic [3:0]           cond;

	assign op   = op_t'(ir[`CU_OP_HI:`CU_OP_LO]);
	assign op2  = op2_t'(ir[`CU_OP2_HI:`CU_OP2_LO]);
	assign op3  = ir[`CU_OP3_HI:`CU_OP3_LO];
	assign cond = ir[`CU_COND_HI:`CU_COND_LO];

	assign imm   = ir[`CU_IMM_BIT];
	assign annul = ir[`CU_ANNUL_BIT];

	always_comb begin
		iclass = ic_illegal;
		case (op)
			op_alu: begin
				if (op3 == op3_jmpl)
					iclass = ic_jmpl;
				else if (op3 inside {[6'b100101:6'b100111]})
					iclass = ic_alu;
				// add/sub/logic family, bit 4 selects the cc form
				else if (op3[5] == 1'b0 && op3[3:0] inside {4'b0000, 4'b1000, 4'b0100,
						4'b1100, 4'b0001, 4'b0101, 4'b0010, 4'b0110, 4'b0011, 4'b0111})
					iclass = op3[4] ? ic_alu_cc : ic_alu;
			end
			op_mem: begin
				if (op3 inside {6'b001001, 6'b001010, 6'b001000, 6'b000001, 6'b000010,
						6'b000011, 6'b001101})
					iclass = ic_load;
				else if (op3 inside {6'b000110, 6'b000100, 6'b000111, 6'b001111})
					iclass = ic_store;
			end
			op_call:
				iclass = ic_call;
			op_branch: begin
				if (op2 == op2_sethi)
					iclass = ic_sethi;
				else if (op2 == op2_bicc)
					iclass = (cond == cond_always) ? ic_br_always : ic_br_cond;
			end
			default:
				iclass = ic_illegal;
		endcase
	end

endmodule

// File: verilog/sequencer.sv
`timescale 1ns/100ps

module sequencer (
	input  logic              Clk,
	input  logic              Clr,
	input  isa_pkg::iclass_t  iclass,
	input  logic              imm,
	input  logic              annul,
	input  logic              moc,
	input  logic              bcond,
	output cu_pkg::cu_state_t state
);
	import isa_pkg::*;
	import cu_pkg::*;

	cu_state_t next_state;

	always_ff @(posedge Clk or negedge Clr) begin
		if (!Clr)
			state <= st_reset;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			st_reset:
				next_state = st_fetch_addr;
			st_fetch_addr:
				next_state = st_fetch_req;
			st_fetch_req:
				next_state = st_fetch_wait;
			// hold until memory reports done
			st_fetch_wait:
				next_state = moc ? st_decode : st_fetch_wait;
			st_decode: begin
				case (iclass)
					ic_alu:       next_state = imm ? st_alu_imm : st_alu_reg;
					ic_alu_cc:    next_state = imm ? st_alu_imm_cc : st_alu_reg_cc;
					ic_sethi:     next_state = st_sethi;
					ic_load:      next_state = imm ? st_ld_addr_imm : st_ld_addr_reg;
					ic_store:     next_state = imm ? st_st_addr_imm : st_st_addr_reg;
					ic_call:      next_state = st_call_link;
					ic_jmpl:      next_state = st_jmpl_link;
					ic_br_always: next_state = st_br_always;
					ic_br_cond: begin
						if (bcond)
							next_state = st_br_target;
						else if (annul)
							next_state = st_br_annul;
						else
							next_state = st_br_skip;
					end
					default:      next_state = st_fetch_addr;
				endcase
			end
			st_alu_reg, st_alu_imm, st_alu_reg_cc, st_alu_imm_cc, st_sethi:
				next_state = st_fetch_addr;
			st_ld_addr_reg, st_ld_addr_imm:
				next_state = st_ld_req;
			st_ld_req:
				next_state = st_ld_wait;
			st_ld_wait:
				next_state = moc ? st_ld_write : st_ld_wait;
			st_ld_write:
				next_state = st_fetch_addr;
			st_st_addr_reg, st_st_addr_imm:
				next_state = st_st_data;
			st_st_data:
				next_state = st_st_wait;
			st_st_wait:
				next_state = moc ? st_st_done : st_st_wait;
			st_st_done:
				next_state = st_fetch_addr;
			st_call_link:
				next_state = st_call_jump;
			st_jmpl_link:
				next_state = imm ? st_jmpl_imm : st_jmpl_reg;
			st_call_jump, st_jmpl_reg, st_jmpl_imm:
				next_state = st_fetch_addr;
			st_br_target:
				next_state = st_br_jump;
			// target already in npc, skip the address phase of fetch
			st_br_jump:
				next_state = st_fetch_req;
			st_br_skip, st_br_annul, st_br_always:
				next_state = st_fetch_addr;
			default:
				next_state = st_reset;
		endcase
	end

endmodule

// File: verilog/control_encoder.sv
`timescale 1ns/100ps

module control_encoder (
	input  cu_pkg::cu_state_t state,
	output logic              reg_win_en,
	output logic              rf_load_en,
	output logic              rf_clear_en,
	output logic              ir_ld,
	output logic              mar_ld,
	output logic              mdr_ld,
	output logic              pc_ld,
	output logic              npc_ld,
	output logic              fr_ld,
	output logic              r_w,
	output logic              mov,
	output logic              mm,
	output logic              mr,
	output logic              mop,
	output logic              msa,
	output cu_pkg::sel2_t     mem_type,
	output cu_pkg::sel2_t     mb,
	output cu_pkg::sel2_t     mnp,
	output cu_pkg::sel2_t     mp,
	output cu_pkg::sel2_t     msc,
	output cu_pkg::alu_op_t   alu_op
);
	import cu_pkg::*;

	logic rf_write;

	// register file write, both window and file enables
	assign rf_write = state inside {st_alu_reg, st_alu_imm, st_alu_reg_cc, st_alu_imm_cc,
		st_sethi, st_ld_write, st_call_link, st_jmpl_link};
	assign rf_load_en  = rf_write;
	assign reg_win_en  = rf_write;
	assign rf_clear_en = (state == st_reset);
	assign mr          = (state == st_reset);

	assign ir_ld  = (state == st_fetch_wait);
	assign mar_ld = state inside {st_fetch_addr, st_br_target, st_ld_addr_reg, st_ld_addr_imm,
		st_st_addr_reg, st_st_addr_imm};
	assign mdr_ld = state inside {st_ld_wait, st_st_data};
	assign fr_ld  = state inside {st_alu_reg_cc, st_alu_imm_cc};

	assign pc_ld  = state inside {st_reset, st_fetch_wait, st_call_jump, st_jmpl_reg,
		st_jmpl_imm, st_br_skip, st_br_annul, st_br_always};
	assign npc_ld = state inside {st_reset, st_fetch_req, st_call_jump, st_jmpl_reg,
		st_jmpl_imm, st_br_jump, st_br_skip, st_br_annul, st_br_always};

	// memory side
	assign r_w = state inside {st_fetch_req, st_fetch_wait, st_ld_addr_reg, st_ld_addr_imm,
		st_ld_req, st_ld_wait, st_st_addr_reg, st_st_addr_imm};
	assign mov = state inside {st_fetch_req, st_fetch_wait, st_ld_req, st_ld_wait,
		st_st_wait, st_st_done};
	assign mm  = state inside {st_st_addr_reg, st_st_addr_imm, st_st_data};
	assign msa = (state == st_st_data);
	assign mop = state inside {st_fetch_addr, st_br_target, st_sethi, st_ld_addr_reg,
		st_ld_addr_imm, st_ld_write, st_st_addr_reg, st_st_addr_imm, st_st_data,
		st_call_link, st_jmpl_link};

	always_comb begin
		mem_type = 2'b00;
		mb       = 2'b00;
		mnp      = 2'b00;
		mp       = 2'b00;
		msc      = 2'b00;
		alu_op   = aop_from_ir;
		case (state)
			st_reset:       mnp = 2'b11;
			// pc + 4 into mar, reused by the taken branch
			st_fetch_addr, st_br_target: begin
				mb     = 2'b10;
				mp     = 2'b11;
				alu_op = aop_add4;
			end
			st_fetch_req: begin
				mem_type = 2'b10;
				mnp      = 2'b11;
			end
			st_fetch_wait: begin
				mem_type = 2'b10;
				mnp      = 2'b11;
				mp       = 2'b11;
			end
			st_alu_imm, st_alu_imm_cc, st_ld_addr_imm, st_st_addr_imm:
				mb = 2'b01;
			st_sethi:       mb = 2'b10;
			st_ld_write: begin
				mb     = 2'b11;
				alu_op = aop_add4;
			end
			st_st_data:     alu_op = aop_pass_b;
			st_call_link, st_jmpl_link: begin
				mb     = 2'b10;
				msc    = (state == st_call_link) ? 2'b01 : 2'b00;
				alu_op = aop_add4;
			end
			st_call_jump, st_br_jump: begin
				mnp = 2'b10;
				mp  = 2'b11;
			end
			st_jmpl_reg:    mp = 2'b11;
			st_jmpl_imm: begin
				mb = 2'b01;
				mp = 2'b11;
			end
			st_br_skip: begin
				mnp = 2'b11;
				mp  = 2'b11;
			end
			// skip the delay slot
			st_br_annul, st_br_always: begin
				mnp = 2'b01;
				mp  = 2'b10;
			end
			default: ;
		endcase
	end

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module control_unit (
	input  logic                Clk,
	input  logic                Clr,
	input  logic [`CU_IR_W-1:0] ir,
	input  logic                moc,
	input  logic                bcond,
	output cu_pkg::cu_state_t   state,
	output logic                reg_win_en,
	output logic                rf_load_en,
	output logic                rf_clear_en,
	output logic                ir_ld,
	output logic                mar_ld,
	output logic                mdr_ld,
	output logic                pc_ld,
	output logic                npc_ld,
	output logic                fr_ld,
	output logic                r_w,
	output logic                mov,
	output logic                mm,
	output logic                mr,
	output logic                mop,
	output logic                msa,
	output cu_pkg::sel2_t       mem_type,
	output cu_pkg::sel2_t       mb,
	output cu_pkg::sel2_t       mnp,
	output cu_pkg::sel2_t       mp,
	output cu_pkg::sel2_t       msc,
	output cu_pkg::alu_op_t     alu_op
);
	import isa_pkg::*;

	iclass_t iclass;
	logic    imm;
	logic    annul;

	instr_decoder decoder_i (
		.ir     (ir),
		.iclass (iclass),
		.imm    (imm),
		.annul  (annul)
	);

	sequencer sequencer_i (
		.Clk    (Clk),
		.Clr    (Clr),
		.iclass (iclass),
		.imm    (imm),
		.annul  (annul),
		.moc    (moc),
		.bcond  (bcond),
		.state  (state)
	);

	control_encoder encoder_i (
		.state       (state),
		.reg_win_en  (reg_win_en),
		.rf_load_en  (rf_load_en),
		.rf_clear_en (rf_clear_en),
		.ir_ld       (ir_ld),
		.mar_ld      (mar_ld),
		.mdr_ld      (mdr_ld),
		.pc_ld       (pc_ld),
		.npc_ld      (npc_ld),
		.fr_ld       (fr_ld),
		.r_w         (r_w),
		.mov         (mov),
		.mm          (mm),
		.mr          (mr),
		.mop         (mop),
		.msa         (msa),
		.mem_type    (mem_type),
		.mb          (mb),
		.mnp         (mnp),
		.mp          (mp),
		.msc         (msc),
		.alu_op      (alu_op)
	);

endmodule

// File: verif/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter real period_ns = 4.0
) (
	output logic Clk
);

	initial begin
		Clk = 1'b0;
		forever #(period_ns / 2.0) Clk = ~Clk;
	end

endmodule

// File: verif/control_unit_tb.sv
`timescale 1ns/100ps
`include "cu_consts.svh"

module control_unit_tb;
	import isa_pkg::*;
	import cu_pkg::*;

	localparam int n_instr       = 400;
	localparam int cycle_limit   = n_instr * 40;
	localparam int reset_cycles  = 10;
	localparam logic [59:0] alu_op3_set   = {6'b000000, 6'b001000, 6'b000100, 6'b001100,
		6'b000001, 6'b000101, 6'b000010, 6'b000110, 6'b000011, 6'b000111};
	localparam logic [41:0] load_op3_set  = {6'b001001, 6'b001010, 6'b001000, 6'b000001,
		6'b000010, 6'b000011, 6'b001101};
	localparam logic [23:0] store_op3_set = {6'b000110, 6'b000100, 6'b000111, 6'b001111};
	localparam logic [17:0] shift_op3_set = {6'b100101, 6'b100110, 6'b100111};

	logic Clk, Clr, moc, bcond;
	logic [`CU_IR_W-1:0] ir;
	cu_state_t state, exp_state, cur;
	logic reg_win_en, rf_load_en, rf_clear_en, ir_ld, mar_ld, mdr_ld, pc_ld, npc_ld;
	logic fr_ld, r_w, mov, mm, mr, mop, msa;
	sel2_t mem_type, mb, mnp, mp, msc;
	alu_op_t alu_op;
	int unsigned r, errors, cycles, issued;
	logic all_done;
	logic [30:0] ctrl_word;
	logic [30:0] ctrl_seen [0:127];
	bit          ctrl_known [0:127];

	tb_clock clock_i (.Clk(Clk));

	control_unit dut_i (
		.Clk(Clk), .Clr(Clr), .ir(ir), .moc(moc), .bcond(bcond), .state(state),
		.reg_win_en(reg_win_en), .rf_load_en(rf_load_en), .rf_clear_en(rf_clear_en),
		.ir_ld(ir_ld), .mar_ld(mar_ld), .mdr_ld(mdr_ld), .pc_ld(pc_ld), .npc_ld(npc_ld),
		.fr_ld(fr_ld), .r_w(r_w), .mov(mov), .mm(mm), .mr(mr), .mop(mop), .msa(msa),
		.mem_type(mem_type), .mb(mb), .mnp(mnp), .mp(mp), .msc(msc), .alu_op(alu_op)
	);

	// every control output, strobes then selects
	assign ctrl_word = {reg_win_en, rf_load_en, rf_clear_en, ir_ld, mar_ld, mdr_ld, pc_ld,
		npc_ld, fr_ld, r_w, mov, mm, mr, mop, msa, mem_type, mb, mnp, mp, msc, alu_op};

	// instruction class from the op/op2/op3/cond fields
	function automatic iclass_t classify_instr(input logic [`CU_IR_W-1:0] w);
		logic [5:0] op3;
		iclass_t c;
		op3 = w[`CU_OP3_HI:`CU_OP3_LO];
		c = ic_illegal;
		case (w[`CU_OP_HI:`CU_OP_LO])
			2'b10: case (op3)
				6'b000000, 6'b001000, 6'b000100, 6'b001100, 6'b000001, 6'b000101,
				6'b000010, 6'b000110, 6'b000011, 6'b000111: c = ic_alu;
				6'b010000, 6'b011000, 6'b010100, 6'b011100, 6'b010001, 6'b010101,
				6'b010010, 6'b010110, 6'b010011, 6'b010111: c = ic_alu_cc;
				6'b100101, 6'b100110, 6'b100111: c = ic_alu;
				6'b111000: c = ic_jmpl;
				default: c = ic_illegal;
			endcase
			2'b11: case (op3)
				6'b001001, 6'b001010, 6'b001000, 6'b000001, 6'b000010, 6'b000011,
				6'b001101: c = ic_load;
				6'b000110, 6'b000100, 6'b000111, 6'b001111: c = ic_store;
				default: c = ic_illegal;
			endcase
			2'b01: c = ic_call;
			default: begin
				if (w[`CU_OP2_HI:`CU_OP2_LO] == 3'b100)
					c = ic_sethi;
				else if (w[`CU_OP2_HI:`CU_OP2_LO] == 3'b010)
					c = (w[`CU_COND_HI:`CU_COND_LO] == cond_always) ? ic_br_always : ic_br_cond;
			end
		endcase
		return c;
	endfunction

	function automatic cu_state_t dispatch_state(input iclass_t c, input logic i,
			input logic a, input logic bc);
		case (c)
			ic_alu:       return i ? st_alu_imm : st_alu_reg;
			ic_alu_cc:    return i ? st_alu_imm_cc : st_alu_reg_cc;
			ic_sethi:     return st_sethi;
			ic_load:      return i ? st_ld_addr_imm : st_ld_addr_reg;
			ic_store:     return i ? st_st_addr_imm : st_st_addr_reg;
			ic_call:      return st_call_link;
			ic_jmpl:      return st_jmpl_link;
			ic_br_always: return st_br_always;
			ic_br_cond:   return bc ? st_br_target : (a ? st_br_annul : st_br_skip);
			default:      return st_fetch_addr;
		endcase
	endfunction

	function automatic cu_state_t expected_next(input cu_state_t s, input logic [31:0] w,
			input logic m, input logic bc);
		case (s)
			st_reset:       return st_fetch_addr;
			st_fetch_addr:  return st_fetch_req;
			st_fetch_req:   return st_fetch_wait;
			st_fetch_wait:  return m ? st_decode : st_fetch_wait;
			st_decode:      return dispatch_state(classify_instr(w), w[`CU_IMM_BIT],
				w[`CU_ANNUL_BIT], bc);
			st_ld_addr_reg, st_ld_addr_imm: return st_ld_req;
			st_ld_req:      return st_ld_wait;
			st_ld_wait:     return m ? st_ld_write : st_ld_wait;
			st_st_addr_reg, st_st_addr_imm: return st_st_data;
			st_st_data:     return st_st_wait;
			st_st_wait:     return m ? st_st_done : st_st_wait;
			st_call_link:   return st_call_jump;
			st_jmpl_link:   return w[`CU_IMM_BIT] ? st_jmpl_imm : st_jmpl_reg;
			st_br_target:   return st_br_jump;
			st_br_jump:     return st_fetch_req;
			// every execute tail goes back to fetch
			default:        return st_fetch_addr;
		endcase
	endfunction

	// random word, then force the fields of one class
	function automatic logic [`CU_IR_W-1:0] make_instr();
		logic [`CU_IR_W-1:0] w;
		w = $urandom;
		case ($urandom % 11)
			0, 1: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b10;
				w[`CU_OP3_HI:`CU_OP3_LO] = alu_op3_set[($urandom % 10) * 6 +: 6];
				// random cc form
				w[`CU_OP3_LO + 4] = w[2];
			end
			2: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b10;
				w[`CU_OP3_HI:`CU_OP3_LO] = shift_op3_set[($urandom % 3) * 6 +: 6];
			end
			3: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b10;
				w[`CU_OP3_HI:`CU_OP3_LO] = 6'b111000;
			end
			4: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b00;
				w[`CU_OP2_HI:`CU_OP2_LO] = 3'b100;
			end
			5: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b11;
				w[`CU_OP3_HI:`CU_OP3_LO] = load_op3_set[($urandom % 7) * 6 +: 6];
			end
			6: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b11;
				w[`CU_OP3_HI:`CU_OP3_LO] = store_op3_set[($urandom % 4) * 6 +: 6];
			end
			7: w[`CU_OP_HI:`CU_OP_LO] = 2'b01;
			8, 9: begin
				w[`CU_OP_HI:`CU_OP_LO] = 2'b00;
				w[`CU_OP2_HI:`CU_OP2_LO] = 3'b010;
				if (w[0])
					w[`CU_COND_HI:`CU_COND_LO] = cond_always;
			end
			default: ;
		endcase
		return w;
	endfunction

	task automatic compare_bit(input string name, input logic got, input logic expv);
		assert (got === expv) else begin
			errors++;
			$display("[ERROR] %0t: %s is %b, expected %b in state %0d", $time, name, got,
				expv, exp_state);
		end
	endtask

	task automatic check_outputs(input cu_state_t s);
		logic rst, rf_wr;
		rst = (s == st_reset);
		rf_wr = (s == st_alu_reg) || (s == st_alu_imm) || (s == st_alu_reg_cc) ||
			(s == st_alu_imm_cc) || (s == st_sethi) || (s == st_ld_write) ||
			(s == st_call_link) || (s == st_jmpl_link);
		assert (state === s) else begin
			errors++;
			$display("[ERROR] %0t: state is %0d, expected %0d", $time, state, s);
		end
		compare_bit("ir_ld", ir_ld, s == st_fetch_wait);
		compare_bit("mar_ld", mar_ld, (s == st_fetch_addr) || (s == st_br_target) ||
			(s == st_ld_addr_reg) || (s == st_ld_addr_imm) || (s == st_st_addr_reg) ||
			(s == st_st_addr_imm));
		compare_bit("mdr_ld", mdr_ld, (s == st_ld_wait) || (s == st_st_data));
		compare_bit("rf_load_en", rf_load_en, rf_wr);
		compare_bit("reg_win_en", reg_win_en, rf_wr);
		compare_bit("fr_ld", fr_ld, (s == st_alu_reg_cc) || (s == st_alu_imm_cc));
		compare_bit("pc_ld", pc_ld, rst || (s == st_fetch_wait) || (s == st_call_jump) ||
			(s == st_jmpl_reg) || (s == st_jmpl_imm) || (s == st_br_skip) ||
			(s == st_br_annul) || (s == st_br_always));
		compare_bit("rf_clear_en", rf_clear_en, rst);
		compare_bit("mr", mr, rst);
		if (rst) begin
			compare_bit("npc_ld", npc_ld, 1'b1);
			compare_bit("r_w", r_w, 1'b0);
			compare_bit("mov", mov, 1'b0);
			compare_bit("mm", mm, 1'b0);
			compare_bit("mop", mop, 1'b0);
			compare_bit("msa", msa, 1'b0);
		end
		// control word must repeat on every visit to a state
		if (!ctrl_known[s]) begin
			ctrl_seen[s] = ctrl_word;
			ctrl_known[s] = 1'b1;
		end
		assert (!$isunknown(ctrl_word) && ctrl_word === ctrl_seen[s]) else begin
			errors++;
			$display("[ERROR] %0t: control word is %h, expected %h in state %0d", $time,
				ctrl_word, ctrl_seen[s], s);
		end
	endtask

	// outputs are settled by the falling edge
	always @(negedge Clk)
		if (cycles > 0)
			check_outputs(exp_state);

	initial begin
		void'($urandom(32'ha847_8e25));
		Clr = 1'b0;
		ir = '0;
		moc = 1'b0;
		bcond = 1'b0;
		exp_state = st_reset;
		errors = 0;
		cycles = 0;
		issued = 0;
		all_done = 1'b0;
		while (!all_done && cycles < cycle_limit) begin
			@(posedge Clk);
			cur = exp_state;
			exp_state = Clr ? expected_next(cur, ir, moc, bcond) : st_reset;
			if (cycles == reset_cycles - 1)
				Clr <= 1'b1;
			// new instruction becomes visible in fetch_wait
			if (Clr && cur == st_fetch_req) begin
				if (issued == n_instr) begin
					all_done = 1'b1;
				end else begin
					ir <= make_instr();
					issued++;
				end
			end
			r = $urandom;
			moc <= r[0];
			bcond <= r[1];
			cycles++;
		end
		@(negedge Clk);
		#1;
		if (!all_done)
			$display("run did not finish in time, stopped after %0d cycles", cycles);
		$display("errors: %0d  instructions: %0d  cycles: %0d", errors, issued, cycles);
		if (errors == 0 && all_done)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/isa_pkg.sv
common/cu_pkg.sv
verilog/instr_decoder.sv
verilog/sequencer.sv
verilog/control_encoder.sv
verilog/control_unit.sv
verif/tb_clock.sv
verif/control_unit_tb.sv
